// ==== logic/ctrl_pkg.sv ====
////////////////////
// core controller definitions
// FSM states, fetch PC select, operand forwarding select,
// decoder jump classes and operand roles of the hazard units
////////////////////

package ctrl_pkg;

  // register source operands a, b and c
  localparam int NUM_OPERANDS = 3;

  // controller FSM states
  typedef enum logic [3:0] {
    RESET       = 4'd0,
    BOOT_SET    = 4'd1,
    FIRST_FETCH = 4'd2,
    DECODE      = 4'd3,
    FLUSH_EX    = 4'd4,
    FLUSH_WB    = 4'd5,
    WAIT_SLEEP  = 4'd6,
    SLEEP       = 4'd7
  } ctrl_state_e;

  // fetch stage PC select
  typedef enum logic [2:0] {
    PC_BOOT      = 3'b000,
    PC_JUMP      = 3'b010,
    PC_BRANCH    = 3'b011,
    PC_EXCEPTION = 3'b100,
    PC_ERET      = 3'b101
  } pc_mux_e;

  // operand source in ID: register file or forwarded result
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fw_sel_e;

  // jump class from the decoder
  typedef enum logic [1:0] {
    BRANCH_NONE = 2'b00,
    BRANCH_JAL  = 2'b01,
    BRANCH_JALR = 2'b10,
    BRANCH_COND = 2'b11
  } jump_kind_e;

  // operand served by one hazard unit
  typedef enum logic [1:0] {
    ROLE_A = 2'd0,
    ROLE_B = 2'd1,
    ROLE_C = 2'd2
  } operand_role_e;

endpackage

// ==== logic/operand_hazard.sv ====
////////////////////
// operand hazard unit
// forwarding select for one source operand, plus the
// load-use and in-flight write hits for the stall logic
////////////////////

`timescale 1ns/1ps

module operand_hazard #(
  parameter ctrl_pkg::operand_role_e OPERAND_ROLE = ctrl_pkg::ROLE_A
) (
  input  logic              ex_match_i,
  input  logic              wb_match_i,
  input  logic              alu_match_i,
  input  logic              regfile_we_ex_i,
  input  logic              regfile_we_wb_i,
  input  logic              regfile_alu_we_fw_i,
  input  logic              data_req_ex_i,
  input  logic              data_misaligned_i,
  input  logic              mult_multicycle_i,
  output ctrl_pkg::fw_sel_e fw_sel_o,
  output logic              load_hit_o,
  output logic              wr_hit_o
);

  logic alu_fw;
  logic wb_fw;

  // result from the EX-stage ALU/MUL writes this operand
  assign alu_fw = alu_match_i & regfile_alu_we_fw_i;
  // result in WB writes this operand
  assign wb_fw  = wb_match_i & regfile_we_wb_i;

  always_comb
  begin
    // EX wins over WB, the younger result is the valid one
    if (alu_fw)
      fw_sel_o = ctrl_pkg::SEL_FW_EX;
    else if (wb_fw)
      fw_sel_o = ctrl_pkg::SEL_FW_WB;
    else
      fw_sel_o = ctrl_pkg::SEL_REGFILE;

    // misaligned access reuses a (address from EX) and b (plain regfile)
    if (data_misaligned_i)
    begin
      if (OPERAND_ROLE == ctrl_pkg::ROLE_A)
        fw_sel_o = ctrl_pkg::SEL_FW_EX;
      else if (OPERAND_ROLE == ctrl_pkg::ROLE_B)
        fw_sel_o = ctrl_pkg::SEL_REGFILE;
    end
    // multicycle multiply keeps its partial result on operand c
    else if (mult_multicycle_i && (OPERAND_ROLE == ctrl_pkg::ROLE_C))
      fw_sel_o = ctrl_pkg::SEL_FW_EX;
  end

  // load in EX targets this operand, data not there yet
  assign load_hit_o = data_req_ex_i & regfile_we_ex_i & ex_match_i;

  // any write still in flight to this operand
  assign wr_hit_o = wb_fw | (ex_match_i & regfile_we_ex_i) | alu_fw;

endmodule

// ==== logic/stall_unit.sv ====
////////////////////
// stall unit
// load-use stall, jump-register stall and
// write-enable deassert for the decoded instruction
////////////////////

`timescale 1ns/1ps

module stall_unit (
  input  logic [ctrl_pkg::NUM_OPERANDS-1:0] load_hit_i,
  input  logic [ctrl_pkg::NUM_OPERANDS-1:0] wr_hit_i,
  input  ctrl_pkg::jump_kind_e              jump_in_dec_i,
  input  logic                              is_decoding_i,
  input  logic                              illegal_insn_i,
  output logic                              load_stall_o,
  output logic                              jr_stall_o,
  output logic                              deassert_we_o
);

  // any operand waiting on a load in EX
  assign load_stall_o = |load_hit_i;

  // jalr target comes from operand a
  // stall while a write to it is still in the pipe
  assign jr_stall_o = (jump_in_dec_i == ctrl_pkg::BRANCH_JALR) & wr_hit_i[0];

  always_comb
  begin
    deassert_we_o = 1'b0;

    // nothing valid in decode
    if (!is_decoding_i)
      deassert_we_o = 1'b1;

    // illegal instruction must not write back
    if (illegal_insn_i)
      deassert_we_o = 1'b1;

    // instruction is replayed after the stall
    if (load_stall_o || jr_stall_o)
      deassert_we_o = 1'b1;
  end

endmodule

// ==== logic/main_fsm.sv ====
////////////////////
// controller FSM
// boot, decode, flush and sleep sequencing, fetch PC
// set/select and the exception and CSR save/restore strobes
////////////////////

`timescale 1ns/1ps

module main_fsm (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 fetch_enable_i,
  input  logic                 instr_valid_i,
  input  logic                 id_ready_i,
  input  logic                 ex_valid_i,
  input  logic                 branch_taken_ex_i,
  input  ctrl_pkg::jump_kind_e jump_in_dec_i,
  input  logic                 jr_stall_i,
  input  logic                 exc_req_i,
  input  logic                 exc_int_req_i,
  input  logic                 ecall_insn_i,
  input  logic                 mret_insn_i,
  input  logic                 ebrk_insn_i,
  input  logic                 pipe_flush_i,
  output logic                 ctrl_busy_o,
  output logic                 first_fetch_o,
  output logic                 is_decoding_o,
  output logic                 instr_req_o,
  output logic                 pc_set_o,
  output ctrl_pkg::pc_mux_e    pc_mux_o,
  output logic                 halt_if_o,
  output logic                 halt_id_o,
  output logic                 exc_ack_o,
  output logic                 exc_done_o,
  output logic                 exc_save_id_o,
  output logic                 csr_save_cause_o,
  output logic                 csr_restore_mret_o
);

  ctrl_pkg::ctrl_state_e state_q;
  ctrl_pkg::ctrl_state_e state_d;
  logic                  jump_done_d;
  logic                  jump_done_q;
  logic                  jump_in_dec;

  // unconditional jumps resolve in ID, conditional ones in EX
  assign jump_in_dec = (jump_in_dec_i == ctrl_pkg::BRANCH_JAL) ||
                       (jump_in_dec_i == ctrl_pkg::BRANCH_JALR);

  ////////////////////
  // next state and outputs
  ////////////////////
  always_comb
  begin
    state_d            = state_q;
    jump_done_d        = jump_done_q;
    ctrl_busy_o        = 1'b1;
    instr_req_o        = 1'b1;
    first_fetch_o      = 1'b0;
    is_decoding_o      = 1'b0;
    pc_set_o           = 1'b0;
    pc_mux_o           = ctrl_pkg::PC_BOOT;
    halt_if_o          = 1'b0;
    halt_id_o          = 1'b0;
    exc_ack_o          = 1'b0;
    exc_done_o         = 1'b0;
    exc_save_id_o      = 1'b0;
    csr_save_cause_o   = 1'b0;
    csr_restore_mret_o = 1'b0;

    case (state_q)
      // idle after reset until fetch is enabled
      ctrl_pkg::RESET:
      begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i)
          state_d = ctrl_pkg::BOOT_SET;
      end

      // load boot address into the fetch PC
      ctrl_pkg::BOOT_SET:
      begin
        pc_set_o = 1'b1;
        pc_mux_o = ctrl_pkg::PC_BOOT;
        state_d  = ctrl_pkg::FIRST_FETCH;
      end

      // wait for the first instruction to reach ID
      ctrl_pkg::FIRST_FETCH:
      begin
        first_fetch_o = 1'b1;
        if (id_ready_i)
          state_d = ctrl_pkg::DECODE;
      end

      ctrl_pkg::DECODE:
      begin
        // taken branch in EX overrides whatever sits in ID
        if (branch_taken_ex_i)
        begin
          pc_set_o = 1'b1;
          pc_mux_o = ctrl_pkg::PC_BRANCH;
        end
        else if (instr_valid_i)
        begin
          is_decoding_o = 1'b1;
          if (exc_req_i)
          begin
            // illegal instruction, drain EX/WB before trapping
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            exc_ack_o = 1'b1;
            state_d   = ctrl_pkg::FLUSH_EX;
          end
          else if (jump_in_dec)
          begin
            pc_mux_o = ctrl_pkg::PC_JUMP;
            // set PC once, and only with the target register settled
            if (!jr_stall_i && !jump_done_q)
            begin
              pc_set_o    = 1'b1;
              jump_done_d = 1'b1;
            end
          end
          else if (mret_insn_i)
          begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = ctrl_pkg::FLUSH_EX;
          end
          else if (ecall_insn_i)
          begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            exc_ack_o = 1'b1;
            state_d   = ctrl_pkg::FLUSH_EX;
          end
          // wfi
          else if (pipe_flush_i)
          begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = ctrl_pkg::FLUSH_EX;
          end
          else if (ebrk_insn_i)
          begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            exc_ack_o = 1'b1;
            state_d   = ctrl_pkg::FLUSH_EX;
          end
        end
      end

      // hold until the instruction in EX completes
      ctrl_pkg::FLUSH_EX:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i)
          state_d = ctrl_pkg::FLUSH_WB;
      end

      // pipe is empty, CSR update is safe now
      ctrl_pkg::FLUSH_WB:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (exc_int_req_i || ecall_insn_i)
        begin
          pc_set_o         = 1'b1;
          pc_mux_o         = ctrl_pkg::PC_EXCEPTION;
          exc_done_o       = 1'b1;
          exc_save_id_o    = 1'b1;
          csr_save_cause_o = 1'b1;
        end
        else if (mret_insn_i)
        begin
          pc_set_o           = 1'b1;
          pc_mux_o           = ctrl_pkg::PC_ERET;
          csr_restore_mret_o = 1'b1;
        end
        else if (ebrk_insn_i)
          exc_done_o = 1'b1;

        state_d = fetch_enable_i ? ctrl_pkg::DECODE : ctrl_pkg::WAIT_SLEEP;
      end

      // one cycle of settling before sleep
      ctrl_pkg::WAIT_SLEEP:
      begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        state_d     = ctrl_pkg::SLEEP;
      end

      ctrl_pkg::SLEEP:
      begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (fetch_enable_i)
          state_d = ctrl_pkg::FIRST_FETCH;
      end

      default:
      begin
        instr_req_o = 1'b0;
        state_d     = ctrl_pkg::RESET;
      end
    endcase
  end

  ////////////////////
  // state registers
  ////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q     <= ctrl_pkg::RESET;
      jump_done_q <= 1'b0;
    end
    else
    begin
      state_q     <= state_d;
      // cleared once ID moves on to the next instruction
      jump_done_q <= jump_done_d & ~id_ready_i;
    end
  end

endmodule

// ==== logic/core_controller.sv ====
////////////////////
// core controller top
// operand hazard units, stall unit and controller FSM
////////////////////

`timescale 1ns/1ps

module core_controller (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 fetch_enable_i,
  input  logic                                 instr_valid_i,
  input  logic                                 id_ready_i,
  input  logic                                 ex_valid_i,
  input  logic                                 branch_taken_ex_i,
  input  ctrl_pkg::jump_kind_e                 jump_in_dec_i,
  input  logic                                 illegal_insn_i,
  input  logic                                 exc_req_i,
  input  logic                                 exc_int_req_i,
  input  logic                                 ecall_insn_i,
  input  logic                                 mret_insn_i,
  input  logic                                 ebrk_insn_i,
  input  logic                                 pipe_flush_i,
  input  logic                                 data_req_ex_i,
  input  logic                                 data_misaligned_i,
  input  logic                                 mult_multicycle_i,
  input  logic                                 regfile_we_ex_i,
  input  logic                                 regfile_we_wb_i,
  input  logic                                 regfile_alu_we_fw_i,
  // bit 0 is operand a
  input  logic [ctrl_pkg::NUM_OPERANDS-1:0]    reg_d_ex_is_reg_i,
  input  logic [ctrl_pkg::NUM_OPERANDS-1:0]    reg_d_wb_is_reg_i,
  input  logic [ctrl_pkg::NUM_OPERANDS-1:0]    reg_d_alu_is_reg_i,
  output ctrl_pkg::fw_sel_e [ctrl_pkg::NUM_OPERANDS-1:0] operand_fw_mux_sel_o,
  output logic                                 load_stall_o,
  output logic                                 jr_stall_o,
  output logic                                 deassert_we_o,
  output logic                                 ctrl_busy_o,
  output logic                                 first_fetch_o,
  output logic                                 is_decoding_o,
  output logic                                 instr_req_o,
  output logic                                 pc_set_o,
  output ctrl_pkg::pc_mux_e                    pc_mux_o,
  output logic                                 halt_if_o,
  output logic                                 halt_id_o,
  output logic                                 exc_ack_o,
  output logic                                 exc_done_o,
  output logic                                 exc_save_id_o,
  output logic                                 csr_save_cause_o,
  output logic                                 csr_restore_mret_o
);

  logic [ctrl_pkg::NUM_OPERANDS-1:0] load_hit;
  logic [ctrl_pkg::NUM_OPERANDS-1:0] wr_hit;

  ////////////////////
  // per-operand hazards
  ////////////////////
  for (genvar k = 0; k < ctrl_pkg::NUM_OPERANDS; k++)
  begin : g_operand
    operand_hazard #(
      .OPERAND_ROLE (ctrl_pkg::operand_role_e'(k))
    ) u_operand_hazard (
      .ex_match_i          (reg_d_ex_is_reg_i[k]),
      .wb_match_i          (reg_d_wb_is_reg_i[k]),
      .alu_match_i         (reg_d_alu_is_reg_i[k]),
      .regfile_we_ex_i     (regfile_we_ex_i),
      .regfile_we_wb_i     (regfile_we_wb_i),
      .regfile_alu_we_fw_i (regfile_alu_we_fw_i),
      .data_req_ex_i       (data_req_ex_i),
      .data_misaligned_i   (data_misaligned_i),
      .mult_multicycle_i   (mult_multicycle_i),
      .fw_sel_o            (operand_fw_mux_sel_o[k]),
      .load_hit_o          (load_hit[k]),
      .wr_hit_o            (wr_hit[k])
    );
  end

  // hits from all operands merge into the stalls
  stall_unit u_stall_unit (
    .load_hit_i     (load_hit),
    .wr_hit_i       (wr_hit),
    .jump_in_dec_i  (jump_in_dec_i),
    .is_decoding_i  (is_decoding_o),
    .illegal_insn_i (illegal_insn_i),
    .load_stall_o   (load_stall_o),
    .jr_stall_o     (jr_stall_o),
    .deassert_we_o  (deassert_we_o)
  );

  ////////////////////
  // controller FSM
  ////////////////////
  main_fsm u_main_fsm (
    .clk                (clk),
    .rst_n              (rst_n),
    .fetch_enable_i     (fetch_enable_i),
    .instr_valid_i      (instr_valid_i),
    .id_ready_i         (id_ready_i),
    .ex_valid_i         (ex_valid_i),
    .branch_taken_ex_i  (branch_taken_ex_i),
    .jump_in_dec_i      (jump_in_dec_i),
    .jr_stall_i         (jr_stall_o),
    .exc_req_i          (exc_req_i),
    .exc_int_req_i      (exc_int_req_i),
    .ecall_insn_i       (ecall_insn_i),
    .mret_insn_i        (mret_insn_i),
    .ebrk_insn_i        (ebrk_insn_i),
    .pipe_flush_i       (pipe_flush_i),
    .ctrl_busy_o        (ctrl_busy_o),
    .first_fetch_o      (first_fetch_o),
    .is_decoding_o      (is_decoding_o),
    .instr_req_o        (instr_req_o),
    .pc_set_o           (pc_set_o),
    .pc_mux_o           (pc_mux_o),
    .halt_if_o          (halt_if_o),
    .halt_id_o          (halt_id_o),
    .exc_ack_o          (exc_ack_o),
    .exc_done_o         (exc_done_o),
    .exc_save_id_o      (exc_save_id_o),
    .csr_save_cause_o   (csr_save_cause_o),
    .csr_restore_mret_o (csr_restore_mret_o)
  );

endmodule

// ==== sim/tb_core_controller.sv ====
////////////////////
// core controller testbench
// boot, forwarding, stalls, jumps and flush/sleep
// checked against reference models of the hazard rules
////////////////////

`timescale 1ns/1ps

module tb_core_controller;

  // cycle budget per test, the watchdog adds a margin on top
  localparam int RESET_CYCLES = 40;
  localparam int FW_CYCLES    = 310;
  localparam int STALL_CYCLES = 210;
  localparam int JUMP_CYCLES  = 30;
  localparam int FLUSH_CYCLES = 60;
  localparam int TEST_CYCLES  = RESET_CYCLES + FW_CYCLES + STALL_CYCLES + JUMP_CYCLES +
                                FLUSH_CYCLES;

  logic clk;
  logic rst_n;
  logic fetch_enable_i;
  logic instr_valid_i;
  logic id_ready_i;
  logic ex_valid_i;
  logic branch_taken_ex_i;
  ctrl_pkg::jump_kind_e jump_in_dec_i;
  logic illegal_insn_i;
  logic exc_req_i;
  logic exc_int_req_i;
  logic ecall_insn_i;
  logic mret_insn_i;
  logic ebrk_insn_i;
  logic pipe_flush_i;
  logic data_req_ex_i;
  logic data_misaligned_i;
  logic mult_multicycle_i;
  logic regfile_we_ex_i;
  logic regfile_we_wb_i;
  logic regfile_alu_we_fw_i;
  logic [ctrl_pkg::NUM_OPERANDS-1:0] reg_d_ex_is_reg_i;
  logic [ctrl_pkg::NUM_OPERANDS-1:0] reg_d_wb_is_reg_i;
  logic [ctrl_pkg::NUM_OPERANDS-1:0] reg_d_alu_is_reg_i;
  ctrl_pkg::fw_sel_e [ctrl_pkg::NUM_OPERANDS-1:0] operand_fw_mux_sel_o;
  logic load_stall_o;
  logic jr_stall_o;
  logic deassert_we_o;
  logic ctrl_busy_o;
  logic first_fetch_o;
  logic is_decoding_o;
  logic instr_req_o;
  logic pc_set_o;
  ctrl_pkg::pc_mux_e pc_mux_o;
  logic halt_if_o;
  logic halt_id_o;
  logic exc_ack_o;
  logic exc_done_o;
  logic exc_save_id_o;
  logic csr_save_cause_o;
  logic csr_restore_mret_o;

  integer seed;
  int     chk_cnt;
  int     err_cnt;
  int     test_chk0;
  int     test_err0;
  // 0 idle, 1 forwarding selects, 2 stall outputs
  int     cmp_mode;

  core_controller dut (.*);

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////
  // reference models
  ////////////////////
  function automatic logic [1:0] ref_fw_sel(input int role, input logic alu_m,
                                            input logic wb_m, input logic alu_we,
                                            input logic wb_we, input logic misaligned,
                                            input logic multicycle);
    // role overrides first
    if (misaligned && role == 0)
      return ctrl_pkg::SEL_FW_EX;
    if (misaligned && role == 1)
      return ctrl_pkg::SEL_REGFILE;
    if (!misaligned && multicycle && role == 2)
      return ctrl_pkg::SEL_FW_EX;
    // then youngest result in flight
    if (alu_m && alu_we)
      return ctrl_pkg::SEL_FW_EX;
    if (wb_m && wb_we)
      return ctrl_pkg::SEL_FW_WB;
    return ctrl_pkg::SEL_REGFILE;
  endfunction

  // {load_stall, jr_stall, deassert_we}
  function automatic logic [2:0] ref_stalls(input logic [2:0] ex_m, input logic [2:0] wb_m,
                                            input logic [2:0] alu_m, input logic we_ex,
                                            input logic we_wb, input logic alu_we,
                                            input logic data_req, input logic [1:0] jump,
                                            input logic decoding, input logic illegal);
    logic load;
    logic write_a;
    logic jr;
    load    = data_req && we_ex && (ex_m != 3'b000);
    write_a = (ex_m[0] && we_ex) || (wb_m[0] && we_wb) || (alu_m[0] && alu_we);
    jr      = (jump == ctrl_pkg::BRANCH_JALR) && write_a;
    return {load, jr, !decoding || illegal || load || jr};
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    chk_cnt++;
    if (exp !== act)
    begin
      err_cnt++;
      $display("[ERROR] %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  // compares the combinational outputs while a random test drives
  always @(posedge clk)
  begin : compare_outputs
    logic [2:0] exp_stall;
    logic       exp_dec;
    if (cmp_mode == 1)
    begin
      for (int k = 0; k < ctrl_pkg::NUM_OPERANDS; k++)
        check($sformatf("forwarding op%0d", k),
              ref_fw_sel(k, reg_d_alu_is_reg_i[k], reg_d_wb_is_reg_i[k], regfile_alu_we_fw_i,
                         regfile_we_wb_i, data_misaligned_i, mult_multicycle_i),
              operand_fw_mux_sel_o[k]);
    end
    else if (cmp_mode == 2)
    begin
      // FSM sits in DECODE, no branch taken
      exp_dec   = instr_valid_i && !branch_taken_ex_i;
      exp_stall = ref_stalls(reg_d_ex_is_reg_i, reg_d_wb_is_reg_i, reg_d_alu_is_reg_i,
                             regfile_we_ex_i, regfile_we_wb_i, regfile_alu_we_fw_i,
                             data_req_ex_i, jump_in_dec_i, exp_dec, illegal_insn_i);
      check("stalls is_decoding", exp_dec, is_decoding_o);
      check("stalls load_stall", exp_stall[2], load_stall_o);
      check("stalls jr_stall", exp_stall[1], jr_stall_o);
      check("stalls deassert_we", exp_stall[0], deassert_we_o);
    end
  end

  // watchdog
  initial
  begin
    repeat (TEST_CYCLES + 200) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", TEST_CYCLES + 200);
    $display("ERRORS FOUND");
    $finish;
  end

  ////////////////////
  // test helpers
  ////////////////////
  task automatic quiet_inputs();
    instr_valid_i       = 1'b0;
    ex_valid_i          = 1'b0;
    branch_taken_ex_i   = 1'b0;
    jump_in_dec_i       = ctrl_pkg::BRANCH_NONE;
    illegal_insn_i      = 1'b0;
    exc_req_i           = 1'b0;
    exc_int_req_i       = 1'b0;
    ecall_insn_i        = 1'b0;
    mret_insn_i         = 1'b0;
    ebrk_insn_i         = 1'b0;
    pipe_flush_i        = 1'b0;
    data_req_ex_i       = 1'b0;
    data_misaligned_i   = 1'b0;
    mult_multicycle_i   = 1'b0;
    regfile_we_ex_i     = 1'b0;
    regfile_we_wb_i     = 1'b0;
    regfile_alu_we_fw_i = 1'b0;
    reg_d_ex_is_reg_i   = '0;
    reg_d_wb_is_reg_i   = '0;
    reg_d_alu_is_reg_i  = '0;
  endtask

  task automatic mark_test_start();
    test_chk0 = chk_cnt;
    test_err0 = err_cnt;
  endtask

  task automatic report_test(input string name);
    $display("test %s finished: %0d checks, %0d mismatches", name, chk_cnt - test_chk0,
             err_cnt - test_err0);
  endtask

  ////////////////////
  // tests
  ////////////////////
  task automatic reset_and_boot();
    mark_test_start();
    // state register is known from the first edge in reset on
    @(posedge clk);
    repeat (15)
    begin
      @(posedge clk);
      check("reset instr_req", 0, instr_req_o);
      check("reset ctrl_busy", 0, ctrl_busy_o);
      check("reset pc_set", 0, pc_set_o);
    end
    @(negedge clk);
    rst_n = 1'b1;
    // idle with fetch disabled
    repeat (3)
    begin
      @(posedge clk);
      check("idle instr_req", 0, instr_req_o);
      check("idle ctrl_busy", 0, ctrl_busy_o);
      check("idle pc_set", 0, pc_set_o);
    end
    @(negedge clk);
    fetch_enable_i = 1'b1;
    @(posedge clk);
    check("boot pc_set early", 0, pc_set_o);
    @(posedge clk);
    check("boot pc_set", 1, pc_set_o);
    check("boot pc_mux", ctrl_pkg::PC_BOOT, pc_mux_o);
    @(posedge clk);
    check("boot pc_set once", 0, pc_set_o);
    check("boot first_fetch", 1, first_fetch_o);
    @(negedge clk);
    id_ready_i = 1'b1;
    @(posedge clk);
    @(posedge clk);
    check("decode first_fetch", 0, first_fetch_o);
    report_test("reset_boot");
  endtask

  task automatic random_forwarding();
    logic [31:0] r;
    mark_test_start();
    repeat (300)
    begin
      @(negedge clk);
      r = $random(seed);
      reg_d_ex_is_reg_i   = r[2:0];
      reg_d_wb_is_reg_i   = r[5:3];
      reg_d_alu_is_reg_i  = r[8:6];
      regfile_we_ex_i     = r[9];
      regfile_we_wb_i     = r[10];
      regfile_alu_we_fw_i = r[11];
      data_misaligned_i   = r[12] & r[14];
      mult_multicycle_i   = r[13];
      cmp_mode            = 1;
    end
    @(negedge clk);
    cmp_mode = 0;
    quiet_inputs();
    report_test("forwarding");
  endtask

  task automatic random_stalls();
    logic [31:0] r;
    mark_test_start();
    repeat (200)
    begin
      @(negedge clk);
      r = $random(seed);
      reg_d_ex_is_reg_i   = r[2:0];
      reg_d_wb_is_reg_i   = r[5:3];
      reg_d_alu_is_reg_i  = r[8:6];
      regfile_we_ex_i     = r[9];
      regfile_we_wb_i     = r[10];
      regfile_alu_we_fw_i = r[11];
      jump_in_dec_i       = ctrl_pkg::jump_kind_e'(r[13:12]);
      data_req_ex_i       = r[14];
      // decoding most of the time
      instr_valid_i       = r[15] | r[16];
      illegal_insn_i      = r[17] & r[18];
      cmp_mode            = 2;
    end
    @(negedge clk);
    cmp_mode = 0;
    quiet_inputs();
    report_test("stalls");
  endtask

  task automatic jump_and_branch();
    int sets;
    mark_test_start();
    sets = 0;
    // jal held in ID by a stalled pipe
    @(negedge clk);
    instr_valid_i = 1'b1;
    jump_in_dec_i = ctrl_pkg::BRANCH_JAL;
    id_ready_i    = 1'b0;
    repeat (6)
    begin
      @(posedge clk);
      if (pc_set_o && pc_mux_o == ctrl_pkg::PC_JUMP)
        sets++;
    end
    @(negedge clk);
    id_ready_i = 1'b1;
    @(posedge clk);
    if (pc_set_o)
      sets++;
    check("jal pc_set count", 1, sets);
    @(negedge clk);
    quiet_inputs();
    @(posedge clk);
    // jalr with a write to operand a still in EX
    @(negedge clk);
    instr_valid_i     = 1'b1;
    jump_in_dec_i     = ctrl_pkg::BRANCH_JALR;
    id_ready_i        = 1'b0;
    reg_d_ex_is_reg_i = 3'b001;
    regfile_we_ex_i   = 1'b1;
    repeat (4)
    begin
      @(posedge clk);
      check("jalr stalled pc_set", 0, pc_set_o);
    end
    @(negedge clk);
    regfile_we_ex_i = 1'b0;
    @(posedge clk);
    check("jalr pc_set", 1, pc_set_o);
    check("jalr pc_mux", ctrl_pkg::PC_JUMP, pc_mux_o);
    @(negedge clk);
    id_ready_i = 1'b1;
    @(posedge clk);
    @(negedge clk);
    quiet_inputs();
    // taken branch from EX
    @(negedge clk);
    branch_taken_ex_i = 1'b1;
    instr_valid_i     = 1'b1;
    @(posedge clk);
    check("branch pc_set", 1, pc_set_o);
    check("branch pc_mux", ctrl_pkg::PC_BRANCH, pc_mux_o);
    @(negedge clk);
    quiet_inputs();
    report_test("jump_branch");
  endtask

  task automatic flush_and_sleep(input logic is_mret);
    int delay;
    delay = {$random(seed)} % 6;
    @(negedge clk);
    instr_valid_i  = 1'b1;
    ecall_insn_i   = !is_mret;
    mret_insn_i    = is_mret;
    fetch_enable_i = 1'b0;
    @(posedge clk);
    check("flush exc_ack", !is_mret, exc_ack_o);
    check("flush halt_id", 1, halt_id_o);
    // EX drains after a variable number of cycles
    repeat (delay)
    begin
      @(posedge clk);
      check("flush_ex halt_if", 1, halt_if_o);
      check("flush_ex pc_set", 0, pc_set_o);
    end
    @(negedge clk);
    ex_valid_i = 1'b1;
    @(posedge clk);
    check("flush_ex end pc_set", 0, pc_set_o);
    @(negedge clk);
    ex_valid_i = 1'b0;
    @(posedge clk);
    check("flush_wb pc_set", 1, pc_set_o);
    check("flush_wb pc_mux", is_mret ? ctrl_pkg::PC_ERET : ctrl_pkg::PC_EXCEPTION, pc_mux_o);
    check("flush_wb exc_done", !is_mret, exc_done_o);
    check("flush_wb exc_save_id", !is_mret, exc_save_id_o);
    check("flush_wb save_cause", !is_mret, csr_save_cause_o);
    check("flush_wb restore_mret", is_mret, csr_restore_mret_o);
    @(negedge clk);
    quiet_inputs();
    // wait_sleep then sleep
    repeat (4)
    begin
      @(posedge clk);
      check("sleep ctrl_busy", 0, ctrl_busy_o);
      check("sleep instr_req", 0, instr_req_o);
    end
    @(negedge clk);
    fetch_enable_i = 1'b1;
    @(posedge clk);
    @(posedge clk);
    check("wake ctrl_busy", 1, ctrl_busy_o);
    check("wake instr_req", 1, instr_req_o);
    check("wake first_fetch", 1, first_fetch_o);
  endtask

  initial
  begin
    seed           = 32'h9ad51236;
    chk_cnt        = 0;
    err_cnt        = 0;
    cmp_mode       = 0;
    rst_n          = 1'b0;
    fetch_enable_i = 1'b0;
    id_ready_i     = 1'b0;
    quiet_inputs();

    reset_and_boot();
    random_forwarding();
    random_stalls();
    jump_and_branch();
    mark_test_start();
    flush_and_sleep(1'b0);
    flush_and_sleep(1'b1);
    report_test("flush_sleep");

    $display("tests done: %0d checks, %0d mismatches", chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== all.f ====
logic/ctrl_pkg.sv
logic/operand_hazard.sv
logic/stall_unit.sv
logic/main_fsm.sv
logic/core_controller.sv
sim/tb_core_controller.sv

// ==== Bender.yml ====
package:
  name: core_controller

sources:
  - logic/ctrl_pkg.sv
  - logic/operand_hazard.sv
  - logic/stall_unit.sv
  - logic/main_fsm.sv
  - logic/core_controller.sv
  - target: simulation
    files:
      - sim/tb_core_controller.sv
